//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = simt_mem_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Errors found

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A run fails when the log holds the fail message or the simulator stopped on an error
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
src/simt_mem_pkg.sv
src/simt_mem_if.sv
src/ld_cmd_apb.sv
src/line_buffer.sv
src/wb_word_select.sv
src/simt_mem_top.sv
verif/simt_mem_checker.sv
verif/simt_mem_tb.sv

//--- src/ld_cmd_apb.sv
`default_nettype none

module ld_cmd_apb #(
	parameter int LINE_COUNT = 16
) (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  simt_mem_pkg::apb_addr_t paddr_i,
	input  simt_mem_pkg::apb_data_t pwdata_i,
	output simt_mem_pkg::apb_data_t prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o,
	mem_req_if.producer             req
);
	import simt_mem_pkg::*;

	localparam int LINE_W = line_idx_w(LINE_COUNT);

	logic                  access;
	logic                  win_hit;
	logic                  line_ok;
	logic                  reg_hit;
	logic                  wr_ok;
	lane_offsets_t         offsets_q;
	thread_mask_t          mask_q;
	reg_addr_t             reg_addr_q;
	warp_id_t              warp_id_q;
	scb_id_t               scb_id_q;
	logic [CMD_LINE_W-1:0] line_q;
	instr_t                instr_q;
	logic [1:0]            issue_q;   // {fb_valid, reg_write}

	assign access   = psel_i & penable_i;
	assign pready_o = 1'b1;           // No wait states

	// Window address is line in bits 8:5 and word in bits 4:2
	assign win_hit = paddr_i < WINDOW_END;
	assign line_ok = int'(paddr_i[8:5]) < LINE_COUNT;

	// The window is write only and the command block is read/write
	assign pslverr_o = access & (win_hit ? (~pwrite_i | ~line_ok) : ~reg_hit);
	assign wr_ok     = access & pwrite_i & ~pslverr_o;

	always_comb
	begin
		reg_hit  = 1'b1;
		prdata_o = '0;
		case (paddr_i)
			REG_OFFSETS: prdata_o = {8'b0, offsets_q};
			REG_CMD:     prdata_o = {10'b0, line_q, scb_id_q, warp_id_q, reg_addr_q, mask_q};
			REG_INSTR:   prdata_o = instr_q;
			REG_ISSUE:   prdata_o = {30'b0, issue_q};
			default:     reg_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			req.wr_valid <= 1'b0;
			req.ld_valid <= 1'b0;
			offsets_q    <= '0;
			mask_q       <= '0;
			reg_addr_q   <= '0;
			warp_id_q    <= '0;
			scb_id_q     <= '0;
			line_q       <= '0;
			instr_q      <= '0;
			issue_q      <= '0;
		end
		else
		begin
			req.wr_valid <= wr_ok & win_hit;
			req.ld_valid <= wr_ok & (paddr_i == REG_ISSUE); // One pulse per issue write
			if (wr_ok)
			begin
				case (paddr_i)
					REG_OFFSETS: offsets_q <= pwdata_i[23:0];
					REG_CMD:
					begin
						mask_q     <= pwdata_i[7:0];
						reg_addr_q <= pwdata_i[12:8];
						warp_id_q  <= pwdata_i[15:13];
						scb_id_q   <= pwdata_i[17:16];
						line_q     <= pwdata_i[21:18];
					end
					REG_INSTR:   instr_q <= pwdata_i;
					REG_ISSUE:   issue_q <= pwdata_i[1:0];
					default:     ;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_ok & win_hit)
		begin
			req.wr_line <= paddr_i[5 +: LINE_W];
			req.wr_word <= paddr_i[4:2];
			req.wr_data <= pwdata_i;
		end
	end

	// Command registers stay put until the buffer has taken them
	assign req.ld_line   = line_q[LINE_W-1:0];
	assign req.offsets   = offsets_q;
	assign req.mask      = mask_q;
	assign req.reg_addr  = reg_addr_q;
	assign req.warp_id   = warp_id_q;
	assign req.scb_id    = scb_id_q;
	assign req.instr     = instr_q;
	assign req.reg_write = issue_q[0];
	assign req.fb_valid  = issue_q[1];

endmodule

`default_nettype wire

//--- src/line_buffer.sv
`default_nettype none

module line_buffer #(
	parameter int LINE_COUNT = 16
) (
	input  logic       clk,
	input  logic       reset_i,
	mem_req_if.buffer  req,
	line_rsp_if.buffer rsp
);
	import simt_mem_pkg::*;

	word_t mem [LINE_COUNT][NUM_LANES];
	line_t rd_line;

	// Each word has its own write enable
	always_ff @(posedge clk)
	begin
		if (req.wr_valid)
			mem[req.wr_line][req.wr_word] <= req.wr_data;
	end

	always_comb
	begin
		for (int w = 0; w < NUM_LANES; w++)
			rd_line[w*WORD_W +: WORD_W] = mem[req.ld_line][w];
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= req.ld_valid;
	end

	// Line and command are captured on the same edge so they stay paired
	always_ff @(posedge clk)
	begin
		if (req.ld_valid)
		begin
			rsp.data      <= rd_line;
			rsp.offsets   <= req.offsets;
			rsp.mask      <= req.mask;
			rsp.reg_addr  <= req.reg_addr;
			rsp.warp_id   <= req.warp_id;
			rsp.scb_id    <= req.scb_id;
			rsp.instr     <= req.instr;
			rsp.reg_write <= req.reg_write;
			rsp.fb_valid  <= req.fb_valid;
		end
	end

endmodule

`default_nettype wire

//--- src/simt_mem_if.sv
`default_nettype none

interface mem_req_if #(
	parameter int LINE_COUNT = 16
);
	import simt_mem_pkg::*;

	localparam int LINE_W = line_idx_w(LINE_COUNT);

	typedef logic [LINE_W-1:0] line_idx_t;

	logic          wr_valid;   // Word write into the line memory
	line_idx_t     wr_line;
	word_sel_t     wr_word;
	word_t         wr_data;

	logic          ld_valid;   // Load issue
	line_idx_t     ld_line;
	lane_offsets_t offsets;
	thread_mask_t  mask;
	reg_addr_t     reg_addr;
	warp_id_t      warp_id;
	scb_id_t       scb_id;
	instr_t        instr;
	logic          reg_write;
	logic          fb_valid;

	modport producer (
		output wr_valid, wr_line, wr_word, wr_data,
		output ld_valid, ld_line, offsets, mask, reg_addr, warp_id, scb_id, instr,
		output reg_write, fb_valid
	);

	modport buffer (
		input wr_valid, wr_line, wr_word, wr_data,
		input ld_valid, ld_line, offsets, mask, reg_addr, warp_id, scb_id, instr,
		input reg_write, fb_valid
	);

endinterface

interface line_rsp_if;
	import simt_mem_pkg::*;

	logic          valid;
	line_t         data;
	lane_offsets_t offsets;
	thread_mask_t  mask;
	reg_addr_t     reg_addr;
	warp_id_t      warp_id;
	scb_id_t       scb_id;
	instr_t        instr;
	logic          reg_write;
	logic          fb_valid;

	modport buffer (
		output valid, data, offsets, mask, reg_addr, warp_id, scb_id, instr, reg_write, fb_valid
	);

	modport consumer (
		input valid, data, offsets, mask, reg_addr, warp_id, scb_id, instr, reg_write, fb_valid
	);

endinterface

`default_nettype wire

//--- src/simt_mem_pkg.sv
`default_nettype none

package simt_mem_pkg;

	localparam int NUM_LANES  = 8;
	localparam int WORD_W     = 32;
	localparam int WORD_SEL_W = 3;
	localparam int MAX_LINES  = 16;
	localparam int CMD_LINE_W = 4; // Line index field of REG_CMD

	typedef logic [WORD_W-1:0]                word_t;
	typedef logic [NUM_LANES*WORD_W-1:0]      line_t; // Lane word 0 in the low bits
	typedef logic [WORD_SEL_W-1:0]            word_sel_t;
	typedef logic [NUM_LANES*WORD_SEL_W-1:0]  lane_offsets_t;
	typedef logic [NUM_LANES-1:0]             thread_mask_t;
	typedef logic [2:0]                       warp_id_t;
	typedef logic [1:0]                       scb_id_t;
	typedef logic [4:0]                       reg_addr_t;
	typedef logic [31:0]                      instr_t;
	typedef logic [11:0]                      apb_addr_t;
	typedef logic [31:0]                      apb_data_t;

	// Line memory window covers the largest supported memory
	localparam apb_addr_t WINDOW_END = apb_addr_t'(MAX_LINES * NUM_LANES * WORD_W / 8);

	localparam apb_addr_t REG_OFFSETS = 12'h200;
	localparam apb_addr_t REG_CMD     = 12'h204;
	localparam apb_addr_t REG_INSTR   = 12'h208;
	localparam apb_addr_t REG_ISSUE   = 12'h20C;

	// Width of a line index, at least one bit even for a single line
	function automatic int line_idx_w(input int line_count);
		return (line_count > 1) ? $clog2(line_count) : 1;
	endfunction

endpackage

`default_nettype wire

//--- src/simt_mem_top.sv
`default_nettype none

module simt_mem_top #(
	parameter int LINE_COUNT = 16
) (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  simt_mem_pkg::apb_addr_t    paddr_i,
	input  simt_mem_pkg::apb_data_t    pwdata_i,
	output simt_mem_pkg::apb_data_t    prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,
	output logic                       reg_write_o,
	output simt_mem_pkg::reg_addr_t    reg_addr_o,
	output simt_mem_pkg::thread_mask_t thread_mask_o,
	output simt_mem_pkg::line_t        reg_write_data_o,
	output simt_mem_pkg::instr_t       instr_o,
	output simt_mem_pkg::thread_mask_t pos_feedback_mask_o,
	output logic                       pos_feedback_valid_o,
	output simt_mem_pkg::warp_id_t     pos_feedback_warpid_o,
	output simt_mem_pkg::scb_id_t      pos_feedback_scbid_o
);
	import simt_mem_pkg::*;

	// The APB window and the REG_CMD line field only reach sixteen lines
	if (LINE_COUNT < 1 || LINE_COUNT > MAX_LINES)
	begin : g_bad_line_count
		$error("LINE_COUNT must be between 1 and %0d", MAX_LINES);
	end

	mem_req_if #(.LINE_COUNT(LINE_COUNT)) req_if ();
	line_rsp_if                           rsp_if ();

	ld_cmd_apb #(
		.LINE_COUNT (LINE_COUNT)
	) ld_cmd_apb_inst (
		.clk       (clk),
		.reset_i   (reset_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.req       (req_if.producer)
	);

	line_buffer #(
		.LINE_COUNT (LINE_COUNT)
	) line_buffer_inst (
		.clk     (clk),
		.reset_i (reset_i),
		.req     (req_if.buffer),
		.rsp     (rsp_if.buffer)
	);

	wb_word_select wb_word_select_inst (
		.clk                   (clk),
		.reset_i               (reset_i),
		.rsp                   (rsp_if.consumer),
		.reg_write_o           (reg_write_o),
		.reg_addr_o            (reg_addr_o),
		.thread_mask_o         (thread_mask_o),
		.reg_write_data_o      (reg_write_data_o),
		.instr_o               (instr_o),
		.pos_feedback_mask_o   (pos_feedback_mask_o),
		.pos_feedback_valid_o  (pos_feedback_valid_o),
		.pos_feedback_warpid_o (pos_feedback_warpid_o),
		.pos_feedback_scbid_o  (pos_feedback_scbid_o)
	);

endmodule

`default_nettype wire

//--- src/wb_word_select.sv
`default_nettype none

module wb_word_select (
	input  logic                       clk,
	input  logic                       reset_i,
	line_rsp_if.consumer               rsp,
	output logic                       reg_write_o,
	output simt_mem_pkg::reg_addr_t    reg_addr_o,
	output simt_mem_pkg::thread_mask_t thread_mask_o,
	output simt_mem_pkg::line_t        reg_write_data_o,
	output simt_mem_pkg::instr_t       instr_o,
	output simt_mem_pkg::thread_mask_t pos_feedback_mask_o,
	output logic                       pos_feedback_valid_o,
	output simt_mem_pkg::warp_id_t     pos_feedback_warpid_o,
	output simt_mem_pkg::scb_id_t      pos_feedback_scbid_o
);
	import simt_mem_pkg::*;

	word_t     line_words [NUM_LANES];
	word_sel_t lane_sel [NUM_LANES];
	line_t     sel_line;

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			line_words[i] = rsp.data[i*WORD_W +: WORD_W];
			lane_sel[i]   = rsp.offsets[i*WORD_SEL_W +: WORD_SEL_W];
		end
	end

	// Lane i gets the word its offset points at, masked lanes included
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
			sel_line[i*WORD_W +: WORD_W] = line_words[lane_sel[i]];
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			reg_write_o          <= 1'b0;
			pos_feedback_valid_o <= 1'b0;
		end
		else
		begin
			reg_write_o          <= rsp.valid & rsp.reg_write;
			pos_feedback_valid_o <= rsp.valid & (rsp.reg_write | rsp.fb_valid); // A register write always frees its slot
		end
	end

	always_ff @(posedge clk)
	begin
		if (rsp.valid)
		begin
			reg_addr_o            <= rsp.reg_addr;
			thread_mask_o         <= rsp.mask;
			reg_write_data_o      <= sel_line;
			instr_o               <= rsp.instr;
			pos_feedback_mask_o   <= rsp.mask;
			pos_feedback_warpid_o <= rsp.warp_id;
			pos_feedback_scbid_o  <= rsp.scb_id;
		end
	end

endmodule

`default_nettype wire

//--- verif/simt_mem_checker.sv
`default_nettype none

module simt_mem_checker (
	input logic                       clk,
	input logic                       reset_i,
	input logic                       pready_i,
	input logic                       reg_write_i,
	input logic                       fb_valid_i,
	input simt_mem_pkg::thread_mask_t fb_mask_i,
	input simt_mem_pkg::thread_mask_t thread_mask_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0; // Read by the testbench at the end of the run

	a_pready_high: assert property (@(posedge clk) disable iff (reset_i) pready_i)
	else
	begin
		fail_count++;
		$error("pready_o went low");
	end

	a_write_has_feedback: assert property (@(posedge clk) disable iff (reset_i)
		reg_write_i |-> fb_valid_i)
	else
	begin
		fail_count++;
		$error("Register write without scoreboard feedback");
	end

	// The feedback mask is the thread mask of the same load
	a_feedback_mask: assert property (@(posedge clk) disable iff (reset_i)
		fb_valid_i |-> (fb_mask_i == thread_mask_i))
	else
	begin
		fail_count++;
		$error("Feedback mask differs from thread mask");
	end

	a_quiet_after_reset: assert property (@(posedge clk) reset_i |=> (!reg_write_i && !fb_valid_i))
	else
	begin
		fail_count++;
		$error("Write-back valid high right after reset");
	end

endmodule

bind simt_mem_top simt_mem_checker simt_mem_checker_inst (
	.clk           (clk),
	.reset_i       (reset_i),
	.pready_i      (pready_o),
	.reg_write_i   (reg_write_o),
	.fb_valid_i    (pos_feedback_valid_o),
	.fb_mask_i     (pos_feedback_mask_o),
	.thread_mask_i (thread_mask_o)
);

`default_nettype wire

//--- verif/simt_mem_tb.sv
`default_nettype none

module simt_mem_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import simt_mem_pkg::*;

	localparam int    LINE_COUNT = 8; // Lines 8 to 15 of the window are then out of range
	localparam string TEST_FILE  = "verif/simt_mem_tests.txt";

	logic         clk = 1'b0;
	logic         reset_i;
	logic         psel_i;
	logic         penable_i;
	logic         pwrite_i;
	apb_addr_t    paddr_i;
	apb_data_t    pwdata_i;
	apb_data_t    prdata_o;
	logic         pready_o;
	logic         pslverr_o;
	logic         reg_write_o;
	reg_addr_t    reg_addr_o;
	thread_mask_t thread_mask_o;
	line_t        reg_write_data_o;
	instr_t       instr_o;
	thread_mask_t pos_feedback_mask_o;
	logic         pos_feedback_valid_o;
	warp_id_t     pos_feedback_warpid_o;
	scb_id_t      pos_feedback_scbid_o;

	int           fd;
	int           n;
	int           line_total;
	int           cycle_count = 0;
	int           cycle_limit = 1000000;
	logic [7:0]   op;
	string        text;
	apb_addr_t    addr;
	apb_data_t    data;
	apb_data_t    rdata;
	logic         err;
	logic         exp_rw;
	logic         exp_fb;
	reg_addr_t    exp_reg;
	thread_mask_t exp_mask;
	warp_id_t     exp_warp;
	scb_id_t      exp_scb;
	instr_t       exp_instr;
	word_t        exp_words [NUM_LANES];
	line_t        exp_line;

	simt_mem_top #(.LINE_COUNT(LINE_COUNT)) simt_mem_top_inst (.*);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (simt_mem_top_inst.simt_mem_checker_inst.fail_count != 0)
		begin
			$display("The bound checker reported an assertion failure");
			stop_with_failure();
		end
		else if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			stop_with_failure();
		end
	end

	task automatic stop_with_failure();
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_mask(input string name, input thread_mask_t got, input thread_mask_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_ids(input warp_id_t got_warp, input warp_id_t exp_warp_id,
		input scb_id_t got_scb, input scb_id_t exp_scb_id);
		if (got_warp !== exp_warp_id)
		begin
			$display("FAILED pos_feedback_warpid_o: got %h, expected %h", got_warp, exp_warp_id);
			stop_with_failure();
		end
		if (got_scb !== exp_scb_id)
		begin
			$display("FAILED pos_feedback_scbid_o: got %h, expected %h", got_scb, exp_scb_id);
			stop_with_failure();
		end
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// Setup cycle, then one access cycle as pready_o is always high
	task automatic apb_transfer(input logic write, input apb_addr_t a, input apb_data_t wdata,
		output apb_data_t rd, output logic slverr);
		@(posedge clk);
		#2;
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = write;
		paddr_i   = a;
		pwdata_i  = wdata;
		@(posedge clk);
		#2;
		penable_i = 1'b1;
		@(negedge clk);
		rd     = prdata_o;
		slverr = pslverr_o;
		@(posedge clk); // Edge 1 of the load timing
		#2;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	// The issue write has just ended, so the outputs settle after two more edges
	task automatic check_load();
		n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", exp_rw, exp_fb, exp_reg,
			exp_mask, exp_warp, exp_scb, exp_instr, exp_words[0], exp_words[1], exp_words[2],
			exp_words[3], exp_words[4], exp_words[5], exp_words[6], exp_words[7]);
		if (n != 15)
		begin
			$display("Load line in %s has %0d fields instead of 15", TEST_FILE, n);
			stop_with_failure();
		end
		for (int i = 0; i < NUM_LANES; i++)
			exp_line[i*WORD_W +: WORD_W] = exp_words[i];
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_bit("reg_write_o", reg_write_o, exp_rw);
		check_bit("pos_feedback_valid_o", pos_feedback_valid_o, exp_fb);
		check_reg_addr("reg_addr_o", reg_addr_o, exp_reg);
		check_mask("thread_mask_o", thread_mask_o, exp_mask);
		check_mask("pos_feedback_mask_o", pos_feedback_mask_o, exp_mask);
		check_ids(pos_feedback_warpid_o, exp_warp, pos_feedback_scbid_o, exp_scb);
		check_word("instr_o", instr_o, exp_instr);
		check_line("reg_write_data_o", reg_write_data_o, exp_line);
		@(posedge clk);
		@(negedge clk);
		check_bit("reg_write_o", reg_write_o, 1'b0); // The valids last a single cycle
		check_bit("pos_feedback_valid_o", pos_feedback_valid_o, 1'b0);
	endtask

	initial
	begin
		reset_i   = 1'b1;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = '0;
		pwdata_i  = '0;

		line_total = 0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
		begin
			$display("Cannot open the test file %s", TEST_FILE);
			stop_with_failure();
		end
		while ($fgets(text, fd) != 0)
			line_total++;
		$fclose(fd);
		cycle_limit = 10 * line_total + 50;
		fd = $fopen(TEST_FILE, "r");

		repeat (5) @(posedge clk);
		#2 reset_i = 1'b0;

		while ($fscanf(fd, " %c", op) == 1)
		begin
			if (op == "#")
				n = $fgets(text, fd);
			else if (op == "L")
				check_load();
			else if (op == "W" || op == "E" || op == "R" || op == "X")
			begin
				n = $fscanf(fd, " %h %h", addr, data);
				if (n != 2)
				begin
					$display("APB line in %s is missing its address or data", TEST_FILE);
					stop_with_failure();
				end
				apb_transfer(op == "W" || op == "E", addr, data, rdata, err);
				check_bit("pslverr_o", err, op == "E" || op == "X"); // E and X expect an error
				if (op == "R")
					check_word("prdata_o", rdata, data);
			end
			else
			begin
				$display("Unknown operation %c in %s", op, TEST_FILE);
				stop_with_failure();
			end
		end
		$fclose(fd);

		if (simt_mem_top_inst.simt_mem_checker_inst.fail_count != 0)
		begin
			$display("The bound checker saw %0d assertion failures",
				simt_mem_top_inst.simt_mem_checker_inst.fail_count);
			stop_with_failure();
		end
		else
		begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/simt_mem_tests.txt
# W/E: addr data write (E expects pslverr), R: addr expected read data, X: addr unused, read expects pslverr
# L: reg_write fb_valid reg_addr mask warp scb instr, then write-back words of lanes 0 to 7
W 000 10000000
W 004 10000001
W 008 10000002
W 00C 10000003
W 010 10000004
W 014 10000005
W 018 10000006
W 01C 10000007
W 0F4 70000005
W 200 00FAC688
W 204 000145FF
W 208 12345678
R 204 000145FF
W 20C 00000001
L 1 1 05 FF 2 1 12345678 10000000 10000001 10000002 10000003 10000004 10000005 10000006 10000007
W 200 0058B63F
W 20C 00000002
L 0 1 05 FF 2 1 12345678 10000007 10000007 10000000 10000003 10000003 10000001 10000006 10000002
W 00C CAFEF00D
W 200 00B6DB6D
W 204 001FFF5A
W 208 DEADBEEF
R 200 00B6DB6D
W 20C 00000000
L 0 0 1F 5A 7 3 DEADBEEF 70000005 70000005 70000005 70000005 70000005 70000005 70000005 70000005
E 10C BAD0BAD0
E 210 11111111
X 000 00000000
W 200 00FAC688
W 204 00022A0F
W 20C 00000003
L 1 1 0A 0F 1 2 DEADBEEF 10000000 10000001 10000002 CAFEF00D 10000004 10000005 10000006 10000007
